/* hw/vec_beat_counter.sv */
`timescale 1ns/1ns

module vec_beat_counter #(
  parameter  int unsigned NrLanes      = 4,
  parameter  int unsigned ElemsPerLane = 4,
  localparam int unsigned VlMax        = NrLanes * ElemsPerLane,
  localparam int unsigned BeatsWidth   = $clog2(ElemsPerLane + 1),
  localparam int unsigned SlotWidth    = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  cnt_start_i,
  input  logic [BeatsWidth-1:0] cnt_beats_i,
  output logic                  cnt_busy_o,
  output logic [SlotWidth-1:0]  beat_idx_o,
  output logic                  cnt_last_o
);

  logic                  busy_q;
  logic [BeatsWidth-1:0] remain_q;
  logic [SlotWidth-1:0]  beat_idx_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q     <= 1'b0;
      remain_q   <= '0;
      beat_idx_q <= '0;
    end else if (cnt_start_i) begin
      // Zero beats leaves the counter idle
      busy_q     <= (cnt_beats_i != '0);
      remain_q   <= cnt_beats_i - 1'b1;
      beat_idx_q <= '0;
    end else if (busy_q) begin
      if (remain_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        remain_q   <= remain_q - 1'b1;
        beat_idx_q <= beat_idx_q + 1'b1;
      end
    end
  end

  assign cnt_busy_o = busy_q;
  assign beat_idx_o = beat_idx_q;
  assign cnt_last_o = busy_q && (remain_q == '0);

  beat_in_range_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cnt_busy_o |-> int'(beat_idx_o) < ElemsPerLane);

  // Requested beats never cover more than one full register
  beats_fit_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cnt_start_i |-> int'(cnt_beats_i) * NrLanes <= VlMax);

endmodule

/* hw/vec_dispatcher.sv */
`timescale 1ns/1ns

module vec_dispatcher #(
  parameter  int unsigned NrLanes      = 4,
  parameter  int unsigned ElemsPerLane = 4,
  localparam int unsigned VlMax        = NrLanes * ElemsPerLane,
  localparam int unsigned VlWidth      = $clog2(VlMax + 1),
  localparam int unsigned BeatsWidth   = $clog2(ElemsPerLane + 1),
  localparam int unsigned SlotWidth    = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1,
  localparam int unsigned LaneSelWidth = (NrLanes > 1) ? $clog2(NrLanes) : 1
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // Host request
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  vec_pkg::vec_op_e              req_op_i,
  input  vec_pkg::vreg_idx_t            req_vd_i,
  input  vec_pkg::vreg_idx_t            req_vs1_i,
  input  vec_pkg::vreg_idx_t            req_vs2_i,
  input  vec_pkg::elem_t                req_scalar_i,
  // Host response
  output logic                          resp_valid_o,
  input  logic                          resp_ready_i,
  output vec_pkg::elem_t                resp_data_o,
  // Beat counter
  output logic                          cnt_start_o,
  output logic [BeatsWidth-1:0]         cnt_beats_o,
  input  logic                          cnt_busy_i,
  input  logic                          cnt_last_i,
  // Broadcast to the lanes
  output vec_pkg::lane_op_e             lane_op_o,
  output vec_pkg::vreg_idx_t            lane_vd_o,
  output vec_pkg::vreg_idx_t            lane_vs1_o,
  output vec_pkg::vreg_idx_t            lane_vs2_o,
  output vec_pkg::elem_t                lane_scalar_o,
  output logic                          lane_we_o,
  output logic [VlWidth-1:0]            vl_o,
  // Single-element access
  output logic [NrLanes-1:0]            elem_we_o,
  output logic [SlotWidth-1:0]          elem_slot_o,
  output vec_pkg::elem_t                elem_wdata_o,
  input  vec_pkg::elem_t [NrLanes-1:0]  elem_rdata_i
);

  localparam int unsigned IdxWidth = 2 * $bits(vec_pkg::vreg_idx_t);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN,
    RESP
  } state_e;

  state_e                  state_q, state_d;
  logic                    req_ready_q;
  logic                    accept;
  logic                    is_vec_op;
  logic                    run_done;
  vec_pkg::lane_op_e       req_alu_op;
  logic [IdxWidth-1:0]     req_elem;
  logic [LaneSelWidth-1:0] req_lane;
  logic [VlWidth:0]        beats_full;

  logic [VlWidth-1:0]      vl_q;
  logic                    cnt_start_q;
  logic [BeatsWidth-1:0]   cnt_beats_q;
  logic [NrLanes-1:0]      elem_we_q;

  vec_pkg::vec_op_e        op_q;
  vec_pkg::lane_op_e       lane_op_q;
  vec_pkg::vreg_idx_t      vd_q;
  vec_pkg::vreg_idx_t      vs1_q;
  vec_pkg::vreg_idx_t      vs2_q;
  vec_pkg::elem_t          scalar_q;
  logic [SlotWidth-1:0]    slot_q;
  logic [LaneSelWidth-1:0] lane_sel_q;
  vec_pkg::elem_t          resp_data_q;

  assign accept = req_valid_i && req_ready_q;

  // Opcode to lane ALU operation
  always_comb begin
    is_vec_op  = 1'b1;
    req_alu_op = vec_pkg::ALU_ADD;
    case (req_op_i)
      vec_pkg::OP_VADD_VV: req_alu_op = vec_pkg::ALU_ADD;
      vec_pkg::OP_VSUB_VV: req_alu_op = vec_pkg::ALU_SUB;
      vec_pkg::OP_VAND_VV: req_alu_op = vec_pkg::ALU_AND;
      vec_pkg::OP_VADD_VX: req_alu_op = vec_pkg::ALU_ADD_SCALAR;
      vec_pkg::OP_VSPLAT:  req_alu_op = vec_pkg::ALU_PASS_SCALAR;
      default:             is_vec_op  = 1'b0;
    endcase
  end

  // Element number {vs1, vs2} wraps at VlMax; lane is e mod NrLanes
  assign req_elem = IdxWidth'({req_vs1_i, req_vs2_i} % VlMax);
  assign req_lane = LaneSelWidth'(req_elem % NrLanes);

  // Beats needed to cover vl elements, rounded up
  assign beats_full = ({1'b0, vl_q} + (VlWidth + 1)'(NrLanes - 1)) / (VlWidth + 1)'(NrLanes);

  // Ends on the last beat, or right away with no beats to run
  assign run_done = cnt_busy_i ? cnt_last_i : (!cnt_start_q || cnt_beats_q == '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = (is_vec_op || req_op_i == vec_pkg::OP_WRITE) ? RUN : DRAIN;
        end
      end
      RUN: begin
        if (run_done) begin
          state_d = DRAIN;
        end
      end
      DRAIN:   state_d = RESP;
      RESP: begin
        if (resp_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= IDLE;
      req_ready_q <= 1'b0;
      vl_q        <= VlWidth'(VlMax);
      cnt_start_q <= 1'b0;
      elem_we_q   <= '0;
    end else begin
      state_q     <= state_d;
      req_ready_q <= (state_d == IDLE);
      // One-cycle pulses
      cnt_start_q <= accept && is_vec_op;
      if (accept && req_op_i == vec_pkg::OP_WRITE) begin
        elem_we_q <= NrLanes'(1) << req_lane;
      end else begin
        elem_we_q <= '0;
      end
      if (accept && req_op_i == vec_pkg::OP_SETVL) begin
        vl_q <= (req_scalar_i > vec_pkg::elem_t'(VlMax)) ? VlWidth'(VlMax)
                                                         : VlWidth'(req_scalar_i);
      end
    end
  end

  // Instruction fields, held for the whole instruction
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q        <= req_op_i;
      lane_op_q   <= req_alu_op;
      vd_q        <= req_vd_i;
      // A read looks at vd through the vs1 read port of every lane
      vs1_q       <= (req_op_i == vec_pkg::OP_READ) ? req_vd_i : req_vs1_i;
      vs2_q       <= req_vs2_i;
      scalar_q    <= req_scalar_i;
      slot_q      <= SlotWidth'(req_elem / NrLanes);
      lane_sel_q  <= req_lane;
      cnt_beats_q <= beats_full[BeatsWidth-1:0];
    end
    if (state_q == DRAIN) begin
      case (op_q)
        vec_pkg::OP_SETVL: resp_data_q <= vec_pkg::elem_t'(vl_q);
        vec_pkg::OP_READ:  resp_data_q <= elem_rdata_i[lane_sel_q];
        default:           resp_data_q <= '0;
      endcase
    end
  end

  assign req_ready_o   = req_ready_q;
  assign resp_valid_o  = (state_q == RESP);
  assign resp_data_o   = resp_data_q;

  assign cnt_start_o   = cnt_start_q;
  assign cnt_beats_o   = cnt_beats_q;

  assign lane_op_o     = lane_op_q;
  assign lane_vd_o     = vd_q;
  assign lane_vs1_o    = vs1_q;
  assign lane_vs2_o    = vs2_q;
  assign lane_scalar_o = scalar_q;
  assign lane_we_o     = (state_q == RUN) && cnt_busy_i;
  assign vl_o          = vl_q;

  assign elem_we_o     = elem_we_q;
  assign elem_slot_o   = slot_q;
  assign elem_wdata_o  = scalar_q;

  // Held response keeps both valid and data until the host takes it
  resp_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o));

endmodule

/* hw/vec_lane.sv */
`timescale 1ns/1ns

module vec_lane #(
  parameter  int unsigned NrLanes      = 4,
  parameter  int unsigned ElemsPerLane = 4,
  parameter  int unsigned LaneId       = 0,
  localparam int unsigned VlMax        = NrLanes * ElemsPerLane,
  localparam int unsigned VlWidth      = $clog2(VlMax + 1),
  localparam int unsigned SlotWidth    = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // Beat control
  input  logic                 beat_valid_i,
  input  logic [SlotWidth-1:0] beat_idx_i,
  input  logic [VlWidth-1:0]   vl_i,
  // Instruction broadcast
  input  vec_pkg::lane_op_e    lane_op_i,
  input  vec_pkg::vreg_idx_t   lane_vd_i,
  input  vec_pkg::vreg_idx_t   lane_vs1_i,
  input  vec_pkg::vreg_idx_t   lane_vs2_i,
  input  vec_pkg::elem_t       lane_scalar_i,
  // Single-element access
  input  logic                 elem_we_i,
  input  logic [SlotWidth-1:0] elem_slot_i,
  input  vec_pkg::elem_t       elem_wdata_i,
  output vec_pkg::elem_t       elem_rdata_o
);

  // This lane's slice of every vector register
  vec_pkg::elem_t       rf_q [vec_pkg::NrVRegs][ElemsPerLane];

  logic [VlWidth-1:0]   elem_no;
  logic                 in_vl;
  logic                 fwd_a;
  logic                 fwd_b;
  vec_pkg::elem_t       opa;
  vec_pkg::elem_t       opb;
  vec_pkg::elem_t       alu_res;

  logic                 wb_valid_q;
  logic [SlotWidth-1:0] wb_slot_q;
  vec_pkg::elem_t       wb_data_q;

  // Global element number of this beat
  assign elem_no = VlWidth'(beat_idx_i) * VlWidth'(NrLanes) + VlWidth'(LaneId);
  assign in_vl   = elem_no < vl_i;

  // Forward the write-back that lands at the end of this cycle
  assign fwd_a = wb_valid_q && (wb_slot_q == beat_idx_i) && (lane_vd_i == lane_vs1_i);
  assign fwd_b = wb_valid_q && (wb_slot_q == beat_idx_i) && (lane_vd_i == lane_vs2_i);

  assign opa = fwd_a ? wb_data_q : rf_q[lane_vs1_i][beat_idx_i];
  assign opb = fwd_b ? wb_data_q : rf_q[lane_vs2_i][beat_idx_i];

  always_comb begin
    case (lane_op_i)
      vec_pkg::ALU_ADD:         alu_res = opa + opb;
      // vs1 minus vs2, wraps at 32 bits
      vec_pkg::ALU_SUB:         alu_res = opa - opb;
      vec_pkg::ALU_AND:         alu_res = opa & opb;
      vec_pkg::ALU_PASS_SCALAR: alu_res = lane_scalar_i;
      vec_pkg::ALU_ADD_SCALAR:  alu_res = opa + lane_scalar_i;
      default:                  alu_res = '0;
    endcase
  end

  // Write-back stage; tail elements never become valid
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= beat_valid_i && in_vl;
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_valid_i) begin
      wb_slot_q <= beat_idx_i;
      wb_data_q <= alu_res;
    end
  end

  // Register file, zero after reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int r = 0; r < vec_pkg::NrVRegs; r++) begin
        for (int s = 0; s < ElemsPerLane; s++) begin
          rf_q[r][s] <= '0;
        end
      end
    end else if (wb_valid_q) begin
      rf_q[lane_vd_i][wb_slot_q] <= wb_data_q;
    end else if (elem_we_i) begin
      rf_q[lane_vd_i][elem_slot_i] <= elem_wdata_i;
    end
  end

  // Host read port
  assign elem_rdata_o = rf_q[lane_vs1_i][elem_slot_i];

  // Host writes only come when no vector op is still draining
  wb_excl_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(elem_we_i && wb_valid_q));

endmodule

/* hw/vec_pkg.sv */
package vec_pkg;

  // Width of one vector element and of the host scalar
  localparam int unsigned ElemWidth = 32;

  typedef logic [ElemWidth-1:0] elem_t;

  // Architectural vector registers
  localparam int unsigned NrVRegs = 8;

  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;

  // Largest lane count the unit is built for
  localparam int unsigned MaxNrLanes = 8;

  // Host opcodes, numbered as the host sends them
  typedef enum logic [2:0] {
    OP_SETVL   = 3'd0,
    OP_VADD_VV = 3'd1,
    OP_VSUB_VV = 3'd2,
    OP_VAND_VV = 3'd3,
    OP_VADD_VX = 3'd4,
    OP_VSPLAT  = 3'd5,
    OP_WRITE   = 3'd6,
    OP_READ    = 3'd7
  } vec_op_e;

  // Operation of the per-lane ALU
  // Operand a is vs1, operand b is vs2
  typedef enum logic [2:0] {
    ALU_ADD         = 3'd0,
    ALU_SUB         = 3'd1,
    ALU_AND         = 3'd2,
    ALU_PASS_SCALAR = 3'd3,
    ALU_ADD_SCALAR  = 3'd4
  } lane_op_e;

endpackage

/* hw/vec_top.sv */
`timescale 1ns/1ns

module vec_top #(
  parameter  int unsigned NrLanes      = 4,
  parameter  int unsigned ElemsPerLane = 4,
  localparam int unsigned VlMax        = NrLanes * ElemsPerLane,
  localparam int unsigned VlWidth      = $clog2(VlMax + 1),
  localparam int unsigned BeatsWidth   = $clog2(ElemsPerLane + 1),
  localparam int unsigned SlotWidth    = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Host request
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  vec_pkg::vec_op_e   req_op_i,
  input  vec_pkg::vreg_idx_t req_vd_i,
  input  vec_pkg::vreg_idx_t req_vs1_i,
  input  vec_pkg::vreg_idx_t req_vs2_i,
  input  vec_pkg::elem_t     req_scalar_i,
  // Host response
  output logic               resp_valid_o,
  input  logic               resp_ready_i,
  output vec_pkg::elem_t     resp_data_o
);

  // Counter control
  logic                          cnt_start;
  logic [BeatsWidth-1:0]         cnt_beats;
  logic                          cnt_busy;
  logic                          cnt_last;
  logic [SlotWidth-1:0]          beat_idx;

  // Lane broadcast
  vec_pkg::lane_op_e             lane_op;
  vec_pkg::vreg_idx_t            lane_vd;
  vec_pkg::vreg_idx_t            lane_vs1;
  vec_pkg::vreg_idx_t            lane_vs2;
  vec_pkg::elem_t                lane_scalar;
  logic                          lane_we;
  logic [VlWidth-1:0]            vl;

  // Single-element access
  logic [NrLanes-1:0]            elem_we;
  logic [SlotWidth-1:0]          elem_slot;
  vec_pkg::elem_t                elem_wdata;
  vec_pkg::elem_t [NrLanes-1:0]  elem_rdata;

  vec_dispatcher #(
    .NrLanes      (NrLanes     ),
    .ElemsPerLane (ElemsPerLane)
  ) i_dispatcher (
    .clk_i         (clk_i       ),
    .arst_n_i      (arst_n_i    ),
    .req_valid_i   (req_valid_i ),
    .req_ready_o   (req_ready_o ),
    .req_op_i      (req_op_i    ),
    .req_vd_i      (req_vd_i    ),
    .req_vs1_i     (req_vs1_i   ),
    .req_vs2_i     (req_vs2_i   ),
    .req_scalar_i  (req_scalar_i),
    .resp_valid_o  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .resp_data_o   (resp_data_o ),
    .cnt_start_o   (cnt_start   ),
    .cnt_beats_o   (cnt_beats   ),
    .cnt_busy_i    (cnt_busy    ),
    .cnt_last_i    (cnt_last    ),
    .lane_op_o     (lane_op     ),
    .lane_vd_o     (lane_vd     ),
    .lane_vs1_o    (lane_vs1    ),
    .lane_vs2_o    (lane_vs2    ),
    .lane_scalar_o (lane_scalar ),
    .lane_we_o     (lane_we     ),
    .vl_o          (vl          ),
    .elem_we_o     (elem_we     ),
    .elem_slot_o   (elem_slot   ),
    .elem_wdata_o  (elem_wdata  ),
    .elem_rdata_i  (elem_rdata  )
  );

  vec_beat_counter #(
    .NrLanes      (NrLanes     ),
    .ElemsPerLane (ElemsPerLane)
  ) i_beat_counter (
    .clk_i       (clk_i    ),
    .arst_n_i    (arst_n_i ),
    .cnt_start_i (cnt_start),
    .cnt_beats_i (cnt_beats),
    .cnt_busy_o  (cnt_busy ),
    .beat_idx_o  (beat_idx ),
    .cnt_last_o  (cnt_last )
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .NrLanes      (NrLanes     ),
      .ElemsPerLane (ElemsPerLane),
      .LaneId       (l           )
    ) i_lane (
      .clk_i         (clk_i        ),
      .arst_n_i      (arst_n_i     ),
      .beat_valid_i  (lane_we      ),
      .beat_idx_i    (beat_idx     ),
      .vl_i          (vl           ),
      .lane_op_i     (lane_op      ),
      .lane_vd_i     (lane_vd      ),
      .lane_vs1_i    (lane_vs1     ),
      .lane_vs2_i    (lane_vs2     ),
      .lane_scalar_i (lane_scalar  ),
      .elem_we_i     (elem_we[l]   ),
      .elem_slot_i   (elem_slot    ),
      .elem_wdata_i  (elem_wdata   ),
      .elem_rdata_o  (elem_rdata[l])
    );
  end : gen_lanes

  // Elaboration checks
  if (NrLanes == 0 || NrLanes != 2**$clog2(NrLanes)) begin : gen_lanes_pow2_check
    $error("vec_top: NrLanes must be a power of two");
  end

  if (NrLanes > vec_pkg::MaxNrLanes) begin : gen_lanes_max_check
    $error("vec_top: NrLanes exceeds the supported maximum");
  end

  if (ElemsPerLane < 1) begin : gen_elems_check
    $error("vec_top: ElemsPerLane must be at least 1");
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the vector unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_vec_top -o tb_vec_top_sim

./obj_dir/tb_vec_top_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

/* tb/tb_vec_top.sv */
`timescale 1ns/1ns

module tb_vec_top;

  localparam int unsigned WordsPerCase = 6;
  localparam int unsigned MaxCases     = 64;
  localparam int unsigned Timeout      = 100;
  localparam logic [31:0] EndMarker    = 32'hffff_ffff;

  logic               clk_i;
  logic               arst_n_i;
  logic               req_valid_i;
  logic               req_ready_o;
  vec_pkg::vec_op_e   req_op_i;
  vec_pkg::vreg_idx_t req_vd_i;
  vec_pkg::vreg_idx_t req_vs1_i;
  vec_pkg::vreg_idx_t req_vs2_i;
  vec_pkg::elem_t     req_scalar_i;
  logic               resp_valid_o;
  logic               resp_ready_i;
  vec_pkg::elem_t     resp_data_o;

  // Six words per case: op, vd, vs1, vs2, scalar, expected
  logic [31:0] case_mem [WordsPerCase*MaxCases];

  int   errors;
  int   timeouts;
  int   cases_run;
  int   seed;
  logic timed_out;

  vec_top DUT (
    .clk_i        (clk_i       ),
    .arst_n_i     (arst_n_i    ),
    .req_valid_i  (req_valid_i ),
    .req_ready_o  (req_ready_o ),
    .req_op_i     (req_op_i    ),
    .req_vd_i     (req_vd_i    ),
    .req_vs1_i    (req_vs1_i   ),
    .req_vs2_i    (req_vs2_i   ),
    .req_scalar_i (req_scalar_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_data_o  (resp_data_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Inputs change and outputs are sampled 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic check_data(input vec_pkg::elem_t got, input vec_pkg::elem_t exp,
                            input int idx);
    if (got !== exp) begin
      $display("ERROR @%0t ns: case %0d returned data %h, expected %h", $time, idx, got, exp);
      errors++;
    end
  endtask

  task automatic check_vl(input vec_pkg::elem_t got, input vec_pkg::elem_t exp, input int idx);
    if (got !== exp) begin
      $display("ERROR @%0t ns: case %0d granted vl %0d, expected %0d", $time, idx, got, exp);
      errors++;
    end
  endtask

  task automatic check_no_accept(input logic ready, input int idx);
    if (ready !== 1'b0) begin
      $display("ERROR @%0t ns: case %0d request ready high with a response pending",
               $time, idx);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what, input int idx);
    $display("Case %0d gave up: %s did not come within %0d cycles", idx, what, Timeout);
    timeouts++;
    timed_out = 1'b1;
  endtask

  task automatic send_request(input int idx);
    int unsigned base;
    int          wait_cycles;
    base         = idx * WordsPerCase;
    req_op_i     = vec_pkg::vec_op_e'(case_mem[base][2:0]);
    req_vd_i     = vec_pkg::vreg_idx_t'(case_mem[base+1][2:0]);
    req_vs1_i    = vec_pkg::vreg_idx_t'(case_mem[base+2][2:0]);
    req_vs2_i    = vec_pkg::vreg_idx_t'(case_mem[base+3][2:0]);
    req_scalar_i = case_mem[base+4];
    req_valid_i  = 1'b1;
    wait_cycles  = 0;
    while (req_ready_o !== 1'b1 && wait_cycles < Timeout) begin
      next_cycle();
      wait_cycles++;
    end
    if (req_ready_o !== 1'b1) begin
      report_timeout("request ready", idx);
    end else begin
      // Transfer happens on the coming edge
      next_cycle();
    end
    req_valid_i = 1'b0;
  endtask

  task automatic collect_response(input int idx);
    int unsigned    base;
    int             wait_cycles;
    int             stall;
    vec_pkg::elem_t got;
    base        = idx * WordsPerCase;
    wait_cycles = 0;
    while (resp_valid_o !== 1'b1 && wait_cycles < Timeout) begin
      check_no_accept(req_ready_o, idx);
      next_cycle();
      wait_cycles++;
    end
    if (resp_valid_o !== 1'b1) begin
      report_timeout("response valid", idx);
    end else begin
      // Random back-pressure of 0 to 3 cycles
      stall = {$random(seed)} % 4;
      repeat (stall) begin
        check_no_accept(req_ready_o, idx);
        next_cycle();
      end
      if (resp_valid_o !== 1'b1) begin
        $display("Case %0d: response valid dropped before the host took it", idx);
        errors++;
      end
      got          = resp_data_o;
      resp_ready_i = 1'b1;
      check_no_accept(req_ready_o, idx);
      next_cycle();
      resp_ready_i = 1'b0;
      if (case_mem[base][2:0] == 3'(vec_pkg::OP_SETVL)) begin
        check_vl(got, case_mem[base+5], idx);
      end else begin
        check_data(got, case_mem[base+5], idx);
      end
    end
  endtask

  initial begin
    int idx;
    req_valid_i  = 1'b0;
    req_op_i     = vec_pkg::OP_SETVL;
    req_vd_i     = '0;
    req_vs1_i    = '0;
    req_vs2_i    = '0;
    req_scalar_i = '0;
    resp_ready_i = 1'b0;
    arst_n_i     = 1'b0;
    errors       = 0;
    timeouts     = 0;
    cases_run    = 0;
    timed_out    = 1'b0;
    seed         = 32'hc1a9318f;
    for (int i = 0; i < WordsPerCase * MaxCases; i++) begin
      case_mem[i] = EndMarker;
    end
    $readmemh("tb/vec_cases.txt", case_mem);

    repeat (8) @(posedge clk_i);
    #10;
    arst_n_i = 1'b1;

    idx = 0;
    while (!timed_out && idx < MaxCases && case_mem[idx*WordsPerCase] !== EndMarker) begin
      send_request(idx);
      if (!timed_out) begin
        collect_response(idx);
      end
      cases_run++;
      idx++;
    end
    if (cases_run == 0) begin
      $display("No cases were read from tb/vec_cases.txt");
      errors++;
    end

    $display("Summary: %0d cases run, %0d errors, %0d timeouts", cases_run, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* tb/vec_cases.txt */
// Columns in hex: op vd vs1 vs2 scalar expected; op numbers follow vec_op_e
// OP_WRITE and OP_READ address element {vs1, vs2}; a lone ffffffff ends the list
// Reads of a register never written
7 7 0 0 00000000 00000000
7 7 1 5 00000000 00000000
// One element per lane written into v1, then read back
6 1 0 0 11111111 00000000
6 1 0 5 22222222 00000000
6 1 1 2 33333333 00000000
6 1 1 7 44444444 00000000
7 1 0 0 00000000 11111111
7 1 0 5 00000000 22222222
7 1 1 2 00000000 33333333
7 1 1 7 00000000 44444444
// Vector length clamps at 16
0 0 0 0 00000007 00000007
0 0 0 0 00000028 00000010
0 0 0 0 00000010 00000010
// Splat, then element-wise add, subtract and AND
5 2 0 0 00000005 00000000
5 3 0 0 fffffffe 00000000
1 4 2 3 00000000 00000000
2 5 2 3 00000000 00000000
3 6 3 1 00000000 00000000
7 4 0 0 00000000 00000003
7 4 1 1 00000000 00000003
7 5 0 6 00000000 00000007
7 5 1 7 00000000 00000007
7 6 0 0 00000000 11111110
7 6 0 5 00000000 22222222
7 6 1 2 00000000 33333332
7 6 1 7 00000000 44444444
7 6 0 3 00000000 00000000
// Scalar add with vl 7 leaves the tail alone
0 0 0 0 00000007 00000007
4 2 2 0 00000100 00000000
7 2 0 3 00000000 00000105
7 2 0 6 00000000 00000105
7 2 0 7 00000000 00000005
7 2 1 4 00000000 00000005
0 0 0 0 00000010 00000010
// Destination equal to a source
1 1 1 1 00000000 00000000
7 1 0 0 00000000 22222222
7 1 0 5 00000000 44444444
7 1 1 2 00000000 66666666
7 1 1 7 00000000 88888888
1 4 4 5 00000000 00000000
7 4 1 6 00000000 0000000a
ffffffff

/* vlog.f */
hw/vec_pkg.sv
hw/vec_beat_counter.sv
hw/vec_lane.sv
hw/vec_dispatcher.sv
hw/vec_top.sv
tb/tb_vec_top.sv
